/* rtl/periph_pkg.sv */
// ------------------------------------------------------------
// peripheral subsystem package
// bus widths, window decode, interrupt counts and the
// register offsets shared by the fabric, timer and PLIC
// ------------------------------------------------------------
`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------
    // bus
    // ------------------------------------------------------------
    localparam int AddrWidth = 12;
    localparam int DataWidth = 32;
    localparam int OffWidth  = 8;
    localparam int WinWidth  = AddrWidth - OffWidth;

    typedef logic [AddrWidth-1:0] reg_addr_t;
    typedef logic [DataWidth-1:0] reg_data_t;
    typedef logic [OffWidth-1:0]  reg_off_t;

    // upper address nibble picks the slave
    typedef enum logic [WinWidth-1:0] {
        win_timer = 4'h0,
        win_plic  = 4'h1,
        win_none  = 4'hf
    } reg_window_e;

    // filler word for disabled slaves and bad offsets
    localparam reg_data_t ErrData = 32'hdeadbeef;

    // ------------------------------------------------------------
    // timer and interrupt sizes
    // ------------------------------------------------------------
    localparam int NumTimers   = 2;
    localparam int NumExtIrq   = 2;
    localparam int NumSources  = NumExtIrq + NumTimers;
    localparam int NumTargets  = 2;
    localparam int MaxPriority = 7;
    localparam int PrioWidth   = $clog2(MaxPriority + 1);
    localparam int SrcIdWidth  = $clog2(NumSources + 1);

    typedef logic [PrioWidth-1:0]  prio_t;
    typedef logic [SrcIdWidth-1:0] src_id_t;
    typedef logic [NumSources-1:0] src_vec_t;
    typedef logic [NumTargets-1:0] tgt_vec_t;

    // timer register within a 16 byte channel slot
    typedef enum logic [1:0] {
        tmr_ctrl = 2'd0,
        tmr_cmp  = 2'd1,
        tmr_cnt  = 2'd2
    } tmr_reg_e;

    // PLIC map
    localparam reg_off_t PlicPendOff   = 8'h20;
    localparam reg_off_t PlicEnBase    = 8'h40;
    localparam reg_off_t PlicThBase    = 8'h80;
    localparam reg_off_t PlicClaimBase = 8'h84;
    localparam int       PlicEnStride  = 4;
    localparam int       PlicCtxStride = 8;

endpackage

`default_nettype wire

/* rtl/reg_fabric.sv */
// ------------------------------------------------------------
// register fabric
// decodes the address window, strobes one peripheral and
// merges the registered results into the bus response
// ------------------------------------------------------------
`default_nettype none

module reg_fabric (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  logic                  req_write_i,
    input  periph_pkg::reg_addr_t req_addr_i,
    input  periph_pkg::reg_data_t req_wdata_i,
    output logic                  sel_timer_o,
    output logic                  sel_plic_o,
    output logic                  wr_o,
    output periph_pkg::reg_off_t  off_o,
    output periph_pkg::reg_data_t wdata_o,
    input  periph_pkg::reg_data_t timer_rdata_i,
    input  periph_pkg::reg_data_t plic_rdata_i,
    input  logic                  timer_err_i,
    input  logic                  plic_err_i,
    output logic                  rsp_valid_o,
    output periph_pkg::reg_data_t rsp_rdata_o,
    output logic                  rsp_err_o
);
    import periph_pkg::*;

    reg_window_e win_d;
    reg_window_e win_q;
    logic        err_mux;

    // ------------------------------------------------------------
    // request side
    // ------------------------------------------------------------
    always_comb begin
        case (req_addr_i[AddrWidth-1:OffWidth])
            win_timer: win_d = win_timer;
            win_plic:  win_d = win_plic;
            default:   win_d = win_none;
        endcase
    end

    assign sel_timer_o = req_valid_i && (win_d == win_timer);
    assign sel_plic_o  = req_valid_i && (win_d == win_plic);
    assign wr_o        = req_write_i;
    assign off_o       = req_addr_i[OffWidth-1:0];
    assign wdata_o     = req_wdata_i;

    // ------------------------------------------------------------
    // response side
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            win_q       <= win_timer;
        end else begin
            rsp_valid_o <= req_valid_i;
            if (req_valid_i) begin
                win_q <= win_d;
            end
        end
    end

    // a miss answers with the filler word
    always_comb begin
        rsp_rdata_o = ErrData;
        err_mux     = 1'b1;
        case (win_q)
            win_timer: begin
                rsp_rdata_o = timer_rdata_i;
                err_mux     = timer_err_i;
            end
            win_plic: begin
                rsp_rdata_o = plic_rdata_i;
                err_mux     = plic_err_i;
            end
            default: ;
        endcase
    end

    assign rsp_err_o = rsp_valid_o & err_mux;

    // one-hot slave select
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(sel_timer_o && sel_plic_o));

endmodule

`default_nettype wire

/* rtl/timer_unit.sv */
// ------------------------------------------------------------
// compare timer block
// free running counters with compare match events, one
// register slot of 16 bytes per channel
// ------------------------------------------------------------
`default_nettype none

module timer_unit (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                sel_i,
    input  logic                                wr_i,
    input  periph_pkg::reg_off_t                off_i,
    input  periph_pkg::reg_data_t               wdata_i,
    output periph_pkg::reg_data_t               rdata_o,
    output logic                                err_o,
    output logic [periph_pkg::NumTimers-1:0]    evt_o
);
    import periph_pkg::*;

    logic [NumTimers-1:0] en_q;
    reg_data_t            cmp_q [NumTimers];
    reg_data_t            cnt_q [NumTimers];

    logic [NumTimers-1:0] ctrl_we;
    logic [NumTimers-1:0] cmp_we;
    logic [NumTimers-1:0] cnt_we;
    reg_data_t            rdata_d;
    logic                 err_d;

    // ------------------------------------------------------------
    // register decode
    // ------------------------------------------------------------
    always_comb begin
        rdata_d = ErrData;
        err_d   = 1'b1;
        ctrl_we = '0;
        cmp_we  = '0;
        cnt_we  = '0;
        for (int c = 0; c < NumTimers; c++) begin
            // channel in bits 7..4, word aligned only
            if (int'(off_i[7:4]) == c && off_i[1:0] == 2'b00) begin
                case (tmr_reg_e'(off_i[3:2]))
                    tmr_ctrl: begin
                        rdata_d    = reg_data_t'(en_q[c]);
                        err_d      = 1'b0;
                        ctrl_we[c] = sel_i & wr_i;
                    end
                    tmr_cmp: begin
                        rdata_d   = cmp_q[c];
                        err_d     = 1'b0;
                        cmp_we[c] = sel_i & wr_i;
                    end
                    tmr_cnt: begin
                        rdata_d   = cnt_q[c];
                        err_d     = 1'b0;
                        cnt_we[c] = sel_i & wr_i;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // counters
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q    <= '0;
            evt_o   <= '0;
            rdata_o <= '0;
            err_o   <= 1'b0;
            for (int c = 0; c < NumTimers; c++) begin
                cmp_q[c] <= '0;
                cnt_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NumTimers; c++) begin
                evt_o[c] <= en_q[c] && (cnt_q[c] == cmp_q[c]);
                // bus write wins over the increment
                if (cnt_we[c]) begin
                    cnt_q[c] <= wdata_i;
                end else if (en_q[c]) begin
                    cnt_q[c] <= (cnt_q[c] == cmp_q[c]) ? '0 : cnt_q[c] + 1'b1;
                end
                if (ctrl_we[c]) begin
                    en_q[c] <= wdata_i[0];
                end
                if (cmp_we[c]) begin
                    cmp_q[c] <= wdata_i;
                end
            end
            if (sel_i) begin
                rdata_o <= rdata_d;
                err_o   <= err_d;
            end
        end
    end

    // a match event comes only from a running channel
    for (genvar c = 0; c < NumTimers; c++) begin : g_evt_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            evt_o[c] |-> $past(en_q[c]));
    end

endmodule

`default_nettype wire

/* rtl/plic_core.sv */
// ------------------------------------------------------------
// platform interrupt controller
// level gateways, per target priority arbitration with
// threshold, and claim/complete handling
// ------------------------------------------------------------
`default_nettype none

module plic_core (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  sel_i,
    input  logic                  wr_i,
    input  periph_pkg::reg_off_t  off_i,
    input  periph_pkg::reg_data_t wdata_i,
    output periph_pkg::reg_data_t rdata_o,
    output logic                  err_o,
    input  periph_pkg::src_vec_t  src_i,
    output periph_pkg::tgt_vec_t  irq_o
);
    import periph_pkg::*;

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    prio_t    prio_q [NumSources];
    src_vec_t pend_q;
    src_vec_t busy_q;
    src_vec_t en_q   [NumTargets];
    prio_t    thr_q  [NumTargets];

    src_id_t  win_id   [NumTargets];
    prio_t    win_prio [NumTargets];

    src_vec_t  prio_we;
    tgt_vec_t  en_we;
    tgt_vec_t  thr_we;
    tgt_vec_t  claim_re;
    tgt_vec_t  cmpl_we;
    src_vec_t  claim_mask;
    src_vec_t  cmpl_mask;
    reg_data_t rdata_d;
    logic      err_d;

    // ------------------------------------------------------------
    // arbitration
    // ------------------------------------------------------------
    // strict compare in ascending order, so ties go to the lower id
    always_comb begin
        for (int t = 0; t < NumTargets; t++) begin
            win_id[t]   = '0;
            win_prio[t] = thr_q[t];
            for (int s = 0; s < NumSources; s++) begin
                if (pend_q[s] && en_q[t][s] && prio_q[s] > win_prio[t]) begin
                    win_id[t]   = src_id_t'(s + 1);
                    win_prio[t] = prio_q[s];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // register decode
    // ------------------------------------------------------------
    always_comb begin
        rdata_d  = '0;
        err_d    = 1'b1;
        prio_we  = '0;
        en_we    = '0;
        thr_we   = '0;
        claim_re = '0;
        cmpl_we  = '0;
        // source ids start at 1, so offset 0 stays unmapped
        for (int s = 0; s < NumSources; s++) begin
            if (off_i == reg_off_t'(4 * (s + 1))) begin
                rdata_d    = reg_data_t'(prio_q[s]);
                err_d      = 1'b0;
                prio_we[s] = sel_i & wr_i;
            end
        end
        if (off_i == PlicPendOff) begin
            rdata_d = reg_data_t'(pend_q);
            err_d   = wr_i;
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (off_i == PlicEnBase + reg_off_t'(PlicEnStride * t)) begin
                rdata_d  = reg_data_t'(en_q[t]);
                err_d    = 1'b0;
                en_we[t] = sel_i & wr_i;
            end
            if (off_i == PlicThBase + reg_off_t'(PlicCtxStride * t)) begin
                rdata_d   = reg_data_t'(thr_q[t]);
                err_d     = 1'b0;
                thr_we[t] = sel_i & wr_i;
            end
            if (off_i == PlicClaimBase + reg_off_t'(PlicCtxStride * t)) begin
                rdata_d     = reg_data_t'(win_id[t]);
                err_d       = 1'b0;
                claim_re[t] = sel_i & !wr_i;
                cmpl_we[t]  = sel_i & wr_i;
            end
        end
        if (err_d) begin
            rdata_d = ErrData;
        end
    end

    // claimed and completed ids as source masks
    always_comb begin
        claim_mask = '0;
        cmpl_mask  = '0;
        for (int t = 0; t < NumTargets; t++) begin
            for (int s = 0; s < NumSources; s++) begin
                if (claim_re[t] && win_id[t] == src_id_t'(s + 1)) begin
                    claim_mask[s] = 1'b1;
                end
                if (cmpl_we[t] && wdata_i == reg_data_t'(s + 1)) begin
                    cmpl_mask[s] = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // gateway, config and outputs
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q  <= '0;
            busy_q  <= '0;
            irq_o   <= '0;
            rdata_o <= '0;
            err_o   <= 1'b0;
            for (int s = 0; s < NumSources; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NumTargets; t++) begin
                en_q[t]  <= '0;
                thr_q[t] <= '0;
            end
        end else begin
            // in-service sources are masked until completed
            pend_q <= (pend_q | (src_i & ~busy_q)) & ~claim_mask;
            busy_q <= (busy_q | claim_mask) & ~cmpl_mask;
            for (int s = 0; s < NumSources; s++) begin
                if (prio_we[s]) begin
                    prio_q[s] <= wdata_i[PrioWidth-1:0];
                end
            end
            for (int t = 0; t < NumTargets; t++) begin
                irq_o[t] <= (win_id[t] != '0);
                if (en_we[t]) begin
                    en_q[t] <= wdata_i[NumSources-1:0];
                end
                if (thr_we[t]) begin
                    thr_q[t] <= wdata_i[PrioWidth-1:0];
                end
            end
            if (sel_i) begin
                rdata_o <= rdata_d;
                err_o   <= err_d;
            end
        end
    end

    // a claim answers with a real source id or none
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        |claim_re |=> rdata_o <= reg_data_t'(NumSources));

endmodule

`default_nettype wire

/* rtl/periph_top.sv */
// ------------------------------------------------------------
// peripheral subsystem top
// register fabric with a compare timer and a PLIC side by side
// ------------------------------------------------------------
`default_nettype none

module periph_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_valid_i,
    input  logic                             req_write_i,
    input  periph_pkg::reg_addr_t            req_addr_i,
    input  periph_pkg::reg_data_t            req_wdata_i,
    output logic                             rsp_valid_o,
    output periph_pkg::reg_data_t            rsp_rdata_o,
    output logic                             rsp_err_o,
    input  logic [periph_pkg::NumExtIrq-1:0] ext_irq_i,
    output periph_pkg::tgt_vec_t             irq_o
);
    import periph_pkg::*;

    logic                 sel_timer;
    logic                 sel_plic;
    logic                 wr;
    reg_off_t             off;
    reg_data_t            wdata;
    reg_data_t            timer_rdata;
    reg_data_t            plic_rdata;
    logic                 timer_err;
    logic                 plic_err;
    logic [NumTimers-1:0] timer_evt;

    reg_fabric i_reg_fabric (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_write_i   ( req_write_i ),
        .req_addr_i    ( req_addr_i  ),
        .req_wdata_i   ( req_wdata_i ),
        .sel_timer_o   ( sel_timer   ),
        .sel_plic_o    ( sel_plic    ),
        .wr_o          ( wr          ),
        .off_o         ( off         ),
        .wdata_o       ( wdata       ),
        .timer_rdata_i ( timer_rdata ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_err_i   ( timer_err   ),
        .plic_err_i    ( plic_err    ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_err_o     ( rsp_err_o   )
    );

    timer_unit i_timer (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .sel_i   ( sel_timer   ),
        .wr_i    ( wr          ),
        .off_i   ( off         ),
        .wdata_i ( wdata       ),
        .rdata_o ( timer_rdata ),
        .err_o   ( timer_err   ),
        .evt_o   ( timer_evt   )
    );

    // external lines are sources 1..2, timer channels 3..4
    plic_core i_plic (
        .clk_i   ( clk_i                  ),
        .rst_n_i ( rst_n_i                ),
        .sel_i   ( sel_plic               ),
        .wr_i    ( wr                     ),
        .off_i   ( off                    ),
        .wdata_i ( wdata                  ),
        .rdata_o ( plic_rdata             ),
        .err_o   ( plic_err               ),
        .src_i   ( {timer_evt, ext_irq_i} ),
        .irq_o   ( irq_o                  )
    );

endmodule

`default_nettype wire

/* tb/tb_periph_top.sv */
// ------------------------------------------------------------
// testbench for the peripheral subsystem
// runs register, interrupt and timer steps from a data file
// ------------------------------------------------------------
`default_nettype none

module tb_periph_top;
    import periph_pkg::*;

    localparam int MaxSteps  = 128;
    localparam int NameBits  = 8 * 24;
    localparam int IrqWait   = 64;
    localparam int StepLimit = 70;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    logic                 req_write;
    reg_addr_t            req_addr;
    reg_data_t            req_wdata;
    logic                 rsp_valid;
    reg_data_t            rsp_rdata;
    logic                 rsp_err;
    logic [NumExtIrq-1:0] ext_irq;
    tgt_vec_t             irq;

    // loaded steps
    logic [7:0]          step_kind [MaxSteps];
    logic [NameBits-1:0] step_name [MaxSteps];
    reg_addr_t           step_addr [MaxSteps];
    reg_data_t           step_data [MaxSteps];
    reg_data_t           step_exp  [MaxSteps];
    logic                step_err  [MaxSteps];
    int                  n_steps;

    int   pass_cnt;
    int   fail_cnt;
    int   cycle_cnt   = 0;
    int   cycle_limit = 1000;
    logic step_ok;

    periph_top dut0 (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_write_i ( req_write ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_err_o   ( rsp_err   ),
        .ext_irq_i   ( ext_irq   ),
        .irq_o       ( irq       )
    );

    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input logic [NameBits-1:0] name, input reg_data_t exp,
                              input reg_data_t act);
        if (act !== exp) begin
            $display("ERR %0s expected %h actual %h", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    task automatic check_err(input logic [NameBits-1:0] name, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("ERR %0s expected err %b actual err %b", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    task automatic check_irq(input logic [NameBits-1:0] name, input tgt_vec_t exp,
                             input tgt_vec_t act);
        if (act !== exp) begin
            $display("%0s: irq_o did not reach %b within %0d cycles, it stayed at %b",
                     name, exp, IrqWait, act);
            step_ok = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic load_steps();
        int                  fd;
        int                  cnt;
        string               line;
        logic [7:0]          kind;
        logic [NameBits-1:0] name;
        reg_addr_t           addr;
        reg_data_t           data;
        reg_data_t           expv;
        logic [3:0]          errv;
        n_steps = 0;
        fd = $fopen("tb/periph_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file tb/periph_testdata.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && n_steps < MaxSteps) begin
                line = "";
                cnt  = $fgets(line, fd);
                // skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    name = '0;
                    cnt  = $sscanf(line, "%s %s %h %h %h %h", kind, name, addr, data,
                                   expv, errv);
                    if (cnt == 6) begin
                        step_kind[n_steps] = kind;
                        step_name[n_steps] = name;
                        step_addr[n_steps] = addr;
                        step_data[n_steps] = data;
                        step_exp[n_steps]  = expv;
                        step_err[n_steps]  = errv[0];
                        n_steps++;
                    end else begin
                        $display("unreadable test data line: %s", line);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called one unit after a rising edge, returns at the same phase
    task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                              output logic got, output logic held,
                              output reg_data_t rdata, output logic err);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req_write = 1'b0;
        // response strobe belongs to the cycle right after the request
        got   = rsp_valid;
        rdata = rsp_rdata;
        err   = rsp_err;
        // and lasts a single cycle
        @(posedge clk);
        #1;
        held = rsp_valid;
    endtask

    task automatic run_step(input int i);
        logic      got;
        logic      held;
        reg_data_t rdata;
        logic      err;
        int        waited;
        step_ok = 1'b1;
        case (step_kind[i])
            "W": begin
                bus_access(1'b1, step_addr[i], step_data[i], got, held, rdata, err);
                if (!got) begin
                    $display("%0s: no response strobe in the cycle after the write",
                             step_name[i]);
                    step_ok = 1'b0;
                end else begin
                    check_err(step_name[i], step_err[i], err);
                end
                if (held) begin
                    $display("%0s: response strobe stayed high for a second cycle",
                             step_name[i]);
                    step_ok = 1'b0;
                end
            end
            "R": begin
                bus_access(1'b0, step_addr[i], '0, got, held, rdata, err);
                if (!got) begin
                    $display("%0s: no response strobe in the cycle after the read",
                             step_name[i]);
                    step_ok = 1'b0;
                end else begin
                    check_data(step_name[i], step_exp[i], rdata);
                    check_err(step_name[i], step_err[i], err);
                end
                if (held) begin
                    $display("%0s: response strobe stayed high for a second cycle",
                             step_name[i]);
                    step_ok = 1'b0;
                end
            end
            "X": begin
                ext_irq = step_data[i][NumExtIrq-1:0];
                @(posedge clk);
                #1;
            end
            "I": begin
                waited = 0;
                while (irq !== tgt_vec_t'(step_exp[i]) && waited < IrqWait) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                check_irq(step_name[i], tgt_vec_t'(step_exp[i]), irq);
            end
            default: begin
                $display("%0s: unknown step kind %s", step_name[i], step_kind[i]);
                step_ok = 1'b0;
            end
        endcase
        if (step_ok) begin
            $display("ok   %0s", step_name[i]);
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        ext_irq   = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        load_steps();
        // reset cycles on top of the per step budget
        cycle_limit = StepLimit * n_steps + 8;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        $display("steps passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && n_steps > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* periph_top.f */
rtl/periph_pkg.sv
rtl/reg_fabric.sv
rtl/timer_unit.sv
rtl/plic_core.sv
rtl/periph_top.sv
tb/tb_periph_top.sv

/* run_sim.sh */
#!/bin/sh
# build the peripheral subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f periph_top.f --top-module tb_periph_top &&
./obj_dir/Vtb_periph_top | tee /dev/stderr | grep -q '^TB PASSED$' &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }

/* tb/periph_testdata.txt */
# kind name addr data expect err, all numbers in hex
# W write, R read, X drive ext_irq_i from data, I wait for irq_o == expect
W cmp0_wr        004 12345678 00000000 0
R cmp0_rd        004 00000000 12345678 0
W prio1_wr       104 0000000d 00000000 0
R prio1_rd       104 00000000 00000005 0
W en0_wr         140 000000ff 00000000 0
R en0_rd         140 00000000 0000000f 0
W thr0_wr        180 0000000a 00000000 0
R thr0_rd        180 00000000 00000002 0
R win2_rd        200 00000000 deadbeef 1
W winf_wr        f00 00000001 00000000 1
R tmr_gap_rd     00c 00000000 deadbeef 1
R plic_gap_rd    100 00000000 deadbeef 1
W pend_wr        120 00000001 00000000 1
X ext1_hi        000 00000001 00000000 0
I irq_ext1       000 00000000 00000001 0
R claim_ext1     184 00000000 00000001 0
X ext1_lo        000 00000000 00000000 0
W cmpl_ext1      184 00000001 00000000 0
I irq_idle_ext   000 00000000 00000000 0
W prio2_hi       108 00000006 00000000 0
X ext12_hi       000 00000003 00000000 0
I irq_arb        000 00000000 00000001 0
R claim_hi       184 00000000 00000002 0
W cmpl_hi        184 00000002 00000000 0
W prio2_tie      108 00000005 00000000 0
R claim_tie_lo   184 00000000 00000001 0
R claim_tie_hi   184 00000000 00000002 0
X ext12_lo       000 00000000 00000000 0
W cmpl_tie_1     184 00000001 00000000 0
W cmpl_tie_2     184 00000002 00000000 0
I irq_idle_arb   000 00000000 00000000 0
W thr0_at_prio   180 00000005 00000000 0
X ext1_thr       000 00000001 00000000 0
R pend_thr       120 00000000 00000001 0
R claim_none     184 00000000 00000000 0
I irq_masked     000 00000000 00000000 0
X ext1_thr_lo    000 00000000 00000000 0
W prio4_wr       110 00000004 00000000 0
W en1_src4       144 00000008 00000000 0
W cmp1_wr        014 00000003 00000000 0
W ctrl1_on       010 00000001 00000000 0
I irq_timer      000 00000000 00000002 0
R claim_timer    18c 00000000 00000004 0
W ctrl1_off      010 00000000 00000000 0
W cmpl_timer     18c 00000004 00000000 0
I irq_idle_tmr   000 00000000 00000000 0
